//--- src/sensor_pkg.sv
/*
 * shared types and constants for the ADS1292 sensor controller
 * opcode codes match the ADS link controller, do not renumber
 * config table is written in array order after link init
 * READ_HOLD_CYCLES is only the default, the top level passes it down
 */
`default_nettype none

package sensor_pkg;

	// ============================================================
	// ADS link opcodes and host commands
	// ============================================================
	typedef enum logic [2:0] {
		ADS_IDLE   = 3'b000,
		ADS_SYSCMD = 3'b001, // system command, not issued here
		ADS_WREG   = 3'b010,
		ADS_RREG   = 3'b011,
		ADS_RDATAC = 3'b100, // continuous conversion on
		ADS_SDATAC = 3'b101, // continuous conversion off
		ADS_DUMMY  = 3'b111  // no-op between commands
	} ads_ctrl_e;

	typedef enum logic [7:0] {
		CMD_RUN      = 8'h52, // 'R'
		CMD_STOP     = 8'h53, // 'S'
		CMD_ADS_READ = 8'h61  // 'a', low byte carries address
	} host_cmd_e;

	typedef logic [7:0]  reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [23:0] sample_t;     // filtered ecg sample
	typedef logic [31:0] host_frame_t; // msb byte goes out first

	typedef struct packed {
		reg_addr_t addr;
		reg_data_t data;
	} cfg_entry_t;

	localparam logic [7:0] FRAME_SYNC_STREAM = 8'hAA;
	localparam logic [7:0] FRAME_SYNC_READ   = 8'h61;

	localparam int READ_HOLD_CYCLES = 5; // idle cycles after a register read

	// ============================================================
	// ADS1292 register table, write order
	// ============================================================
	localparam int ADS_CFG_LEN = 11;
	localparam cfg_entry_t ADS_CFG_TABLE [ADS_CFG_LEN] = '{
		'{8'h09, 8'h02}, // RESP1
		'{8'h0A, 8'h87}, // RESP2, bit2 must be 1
		'{8'h01, 8'h01}, // CONFIG1
		'{8'h02, 8'hE0}, // CONFIG2
		'{8'h03, 8'h10}, // LOFF
		'{8'h04, 8'h00}, // CH1SET
		'{8'h05, 8'h00}, // CH2SET
		'{8'h06, 8'h2C}, // RLD_SENS
		'{8'h07, 8'h0E}, // LOFF_SENS
		'{8'h08, 8'h40}, // LOFF_STAT, fmod = fclk/16
		'{8'h0B, 8'h00}  // GPIO
	};

endpackage

`default_nettype wire

//--- src/ads_req_if.sv
/*
 * request/completion bundle between the control side and the ADS sequencer
 * every request is a level held until its done is seen
 * rd_done and sample_new are single-cycle pulses
 */
`timescale 1ns/1ps
`default_nettype none

interface ads_req_if import sensor_pkg::*; ();
	logic      cfg_req;    // write the register table
	logic      run_req;    // continuous conversion wanted
	logic      rd_req;     // single register read
	reg_addr_t rd_addr;
	logic      cfg_done;   // sticky until reset
	logic      run_done;   // follows run_req
	logic      rd_done;
	reg_data_t rd_data;    // valid with rd_done
	sample_t   sample;
	logic      sample_new;

	modport ctrl (output cfg_req, run_req, rd_req, rd_addr,
		input cfg_done, run_done, rd_done, rd_data, sample, sample_new);
	modport seq (input cfg_req, run_req, rd_req, rd_addr,
		output cfg_done, run_done, rd_done, rd_data, sample, sample_new);
endinterface

`default_nettype wire

//--- src/core_control.sv
/*
 * bring-up and run/stop control
 * nothing is requested before the ADS link reports its own init
 * run_req is only forwarded once the register table is written
 */
`timescale 1ns/1ps
`default_nettype none

module core_control (
	input  wire logic i_CLK,
	input  wire logic i_RST,
	input  wire logic i_ads_init_set, // link init finished
	input  wire logic i_run_mode,     // run wish from host side
	ads_req_if.ctrl   bus
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_INIT,
		S_CHIP_SET,
		S_STANDBY,
		S_READING
	} state_e;

	state_e state;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			bus.cfg_req <= 1'b0;
			bus.run_req <= 1'b0;
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					bus.cfg_req <= 1'b0;
					bus.run_req <= 1'b0;
					state <= S_WAIT_INIT;
				end
				S_WAIT_INIT: if (i_ads_init_set) state <= S_CHIP_SET;
				S_CHIP_SET: begin
					bus.cfg_req <= !bus.cfg_done; // drop once table is in
					if (bus.cfg_done) state <= S_STANDBY;
				end
				S_STANDBY: begin
					bus.run_req <= i_run_mode;
					if (i_run_mode && bus.run_done) state <= S_READING; // RDATAC went out
				end
				S_READING: begin
					bus.run_req <= i_run_mode; // low here triggers SDATAC
					if (!i_run_mode) state <= S_STANDBY;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// conversion must never start on an unconfigured chip
	a_run_after_cfg: assert property (@(posedge i_CLK) disable iff (i_RST)
		bus.run_req |-> bus.cfg_done)
		else $error("run_req raised before cfg_done");

endmodule

`default_nettype wire

//--- src/host_link.sv
/*
 * uart side: 16-bit command decode and 32-bit frame build
 * one stream sample is buffered, a newer one overwrites it
 * stream frames win over a pending register frame
 * valid is only raised after a ready cycle, one frame per offer
 */
`timescale 1ns/1ps
`default_nettype none

module host_link import sensor_pkg::*; (
	input  wire logic        i_CLK,
	input  wire logic        i_RST,
	input  wire logic [15:0] i_uart_rx,       // {cmd, arg}
	input  wire logic        i_uart_rx_valid,
	output host_frame_t      o_uart_tx,
	output logic             o_uart_tx_valid,
	input  wire logic        i_uart_tx_ready,
	output logic             o_run_mode,
	ads_req_if.ctrl          bus
);

	typedef enum logic {
		S_STANDBY,
		S_RX
	} state_e;

	state_e      state;
	logic [15:0] rx_word;
	host_cmd_e   rx_cmd;
	sample_t     stream_buf;   // newest unsent sample
	logic        stream_pend;
	reg_data_t   rd_data_l;
	logic        rd_pend;      // register frame waiting
	logic        tx_is_stream; // kind of frame on the wire
	logic        stream_avail;
	logic        tx_raise;
	logic        tx_take;

	assign rx_cmd       = host_cmd_e'(rx_word[15:8]);
	assign stream_avail = stream_pend | bus.sample_new; // bypass saves a cycle
	assign tx_raise     = !o_uart_tx_valid && i_uart_tx_ready && (stream_avail || rd_pend);
	assign tx_take      = o_uart_tx_valid && i_uart_tx_ready;

	// command word and frame payload
	always_ff @(posedge i_CLK) begin
		if (state == S_STANDBY && i_uart_rx_valid) rx_word <= i_uart_rx;
		if (bus.sample_new) stream_buf <= bus.sample;
		if (bus.rd_done) rd_data_l <= bus.rd_data;
		if (tx_raise) begin
			if (stream_avail)
				o_uart_tx <= {FRAME_SYNC_STREAM, (bus.sample_new ? bus.sample : stream_buf)};
			else
				o_uart_tx <= {FRAME_SYNC_READ, bus.rd_addr, rd_data_l, 8'h00};
		end
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			state <= S_STANDBY;
			o_run_mode <= 1'b0;
			bus.rd_req <= 1'b0;
			bus.rd_addr <= '0;
			stream_pend <= 1'b0;
			rd_pend <= 1'b0;
			tx_is_stream <= 1'b0;
			o_uart_tx_valid <= 1'b0;
		end else begin
			// ============================================================
			// command decode
			// ============================================================
			case (state)
				S_STANDBY: if (i_uart_rx_valid) state <= S_RX;
				S_RX: begin
					case (rx_cmd)
						CMD_RUN:  o_run_mode <= 1'b1;
						CMD_STOP: o_run_mode <= 1'b0;
						CMD_ADS_READ: begin
							if (!bus.rd_req && !rd_pend) begin // one read in flight
								bus.rd_req <= 1'b1;
								bus.rd_addr <= rx_word[7:0];
							end
						end
						default: ; // unknown byte is dropped
					endcase
					state <= S_STANDBY;
				end
				default: state <= S_STANDBY;
			endcase

			// ============================================================
			// transmit
			// ============================================================
			o_uart_tx_valid <= tx_raise;
			if (tx_raise) tx_is_stream <= stream_avail;
			if (tx_take) begin
				if (tx_is_stream) stream_pend <= 1'b0;
				else rd_pend <= 1'b0;
			end
			if (bus.sample_new) stream_pend <= 1'b1; // newer sample wins over clear
			if (bus.rd_done) begin
				bus.rd_req <= 1'b0;
				rd_pend <= 1'b1;
			end
		end
	end

	a_valid_after_ready: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_uart_tx_valid |-> $past(i_uart_tx_ready))
		else $error("tx valid raised without ready");

endmodule

`default_nettype wire

//--- src/ads_sequencer.sv
/*
 * ADS1292 command sequencer, one command at a time
 * opcodes last one cycle then DUMMY, busy is checked from the next cycle on
 * reads are only served after the table is written and while not streaming
 * P_READ_HOLD idle cycles follow each read, valid range 1..15
 */
`timescale 1ns/1ps
`default_nettype none

module ads_sequencer import sensor_pkg::*; #(
	parameter int P_READ_HOLD = 5
) (
	input  wire logic      i_CLK,
	input  wire logic      i_RST,
	output ads_ctrl_e      o_ads_control,
	output reg_addr_t      o_ads_reg_addr,
	output reg_data_t      o_ads_data_in,
	input  wire reg_data_t i_ads_reg_data,
	input  wire logic      i_ads_busy,
	input  wire sample_t   i_ads_sample,
	input  wire logic      i_ads_sample_valid,
	output logic           o_ads_sample_ack,
	ads_req_if.seq         bus
);

	localparam int CNT_W = $clog2(ADS_CFG_LEN + 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_SETTING,
		S_WREG_INIT,
		S_WREG_CONFIRM,
		S_RREG_INIT,
		S_RREG_CONFIRM,
		S_RREG_WAIT,
		S_RUN,
		S_STREAM,
		S_STREAM_ACK,
		S_STOP
	} state_e;

	state_e           state;
	logic [CNT_W-1:0] cfg_cnt;  // table index
	logic [3:0]       hold_cnt; // post-read idle

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_ads_control <= ADS_IDLE;
			o_ads_reg_addr <= '0;
			o_ads_data_in <= '0;
			o_ads_sample_ack <= 1'b0;
			bus.cfg_done <= 1'b0;
			bus.run_done <= 1'b0;
			bus.rd_done <= 1'b0;
			bus.rd_data <= '0;
			bus.sample <= '0;
			bus.sample_new <= 1'b0;
			cfg_cnt <= '0;
			hold_cnt <= '0;
			state <= S_IDLE;
		end else begin
			// pulses and opcode fall back by default
			o_ads_control <= ADS_DUMMY;
			o_ads_sample_ack <= 1'b0;
			bus.sample_new <= 1'b0;
			bus.rd_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (bus.cfg_req && !bus.cfg_done) begin
						state <= S_SETTING;
					end else if (bus.run_req && !bus.run_done) begin
						o_ads_control <= ADS_RDATAC;
						state <= S_RUN;
					end else if (bus.rd_req && bus.cfg_done) begin
						o_ads_reg_addr <= bus.rd_addr;
						o_ads_control <= ADS_RREG;
						state <= S_RREG_INIT;
					end
				end
				// ============================================================
				// register table walk
				// ============================================================
				S_SETTING: begin
					if (cfg_cnt == CNT_W'(ADS_CFG_LEN)) begin
						bus.cfg_done <= 1'b1; // stays until reset
						state <= S_IDLE;
					end else begin
						o_ads_reg_addr <= ADS_CFG_TABLE[cfg_cnt].addr;
						o_ads_data_in <= ADS_CFG_TABLE[cfg_cnt].data;
						o_ads_control <= ADS_WREG;
						cfg_cnt <= cfg_cnt + 1'b1;
						state <= S_WREG_INIT;
					end
				end
				S_WREG_INIT: state <= S_WREG_CONFIRM; // WREG on the wire, busy rises
				S_WREG_CONFIRM: if (!i_ads_busy) state <= S_SETTING;
				// ============================================================
				// single register read
				// ============================================================
				S_RREG_INIT: state <= S_RREG_CONFIRM;
				S_RREG_CONFIRM: begin
					if (!i_ads_busy) begin
						bus.rd_data <= i_ads_reg_data;
						bus.rd_done <= 1'b1;
						hold_cnt <= '0;
						state <= S_RREG_WAIT;
					end
				end
				S_RREG_WAIT: begin
					// gives host side time to drop rd_req
					if (hold_cnt == 4'(P_READ_HOLD - 1)) state <= S_IDLE;
					else hold_cnt <= hold_cnt + 1'b1;
				end
				// ============================================================
				// continuous conversion
				// ============================================================
				S_RUN: begin
					bus.run_done <= 1'b1; // RDATAC went out last cycle
					state <= S_STREAM;
				end
				S_STREAM: begin
					if (!bus.run_req) begin
						o_ads_control <= ADS_SDATAC;
						state <= S_STOP;
					end else if (i_ads_sample_valid) begin
						bus.sample <= i_ads_sample;
						bus.sample_new <= 1'b1;
						o_ads_sample_ack <= 1'b1;
						state <= S_STREAM_ACK;
					end
				end
				S_STREAM_ACK: state <= S_STREAM; // link drops valid on ack
				S_STOP: begin
					bus.run_done <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_cmd_one_cycle: assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_ads_control inside {ADS_WREG, ADS_RREG, ADS_RDATAC, ADS_SDATAC})
		|=> o_ads_control == ADS_DUMMY)
		else $error("command opcode held past one cycle");

	a_ack_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_ads_sample_ack |=> !o_ads_sample_ack)
		else $error("sample ack high two cycles in a row");

endmodule

`default_nettype wire

//--- src/sensor_core.sv
/*
 * sensor controller top, ADS1292 only
 * host frames are 32 bits: AA + sample, or 61 + addr + data + 00
 * all state lives in the three submodules
 */
`timescale 1ns/1ps
`default_nettype none

module sensor_core import sensor_pkg::*; #(
	parameter int P_READ_HOLD = READ_HOLD_CYCLES
) (
	input  wire logic        i_CLK,
	input  wire logic        i_RST,
	// uart side
	output host_frame_t      o_uart_tx,
	output logic             o_uart_tx_valid,
	input  wire logic        i_uart_tx_ready,
	input  wire logic [15:0] i_uart_rx,
	input  wire logic        i_uart_rx_valid,
	// ADS link side
	output ads_ctrl_e        o_ads_control,
	output reg_addr_t        o_ads_reg_addr,
	output reg_data_t        o_ads_data_in,
	input  wire reg_data_t   i_ads_reg_data,
	input  wire logic        i_ads_init_set,
	input  wire logic        i_ads_busy,
	input  wire sample_t     i_ads_sample,
	input  wire logic        i_ads_sample_valid,
	output logic             o_ads_sample_ack
);

	logic run_mode; // host run wish

	ads_req_if u_req ();

	core_control u_ctrl (
		.i_CLK(i_CLK), .i_RST(i_RST), .i_ads_init_set(i_ads_init_set),
		.i_run_mode(run_mode), .bus(u_req.ctrl)
	);

	host_link u_host (
		.i_CLK(i_CLK), .i_RST(i_RST), .i_uart_rx(i_uart_rx),
		.i_uart_rx_valid(i_uart_rx_valid), .o_uart_tx(o_uart_tx),
		.o_uart_tx_valid(o_uart_tx_valid), .i_uart_tx_ready(i_uart_tx_ready),
		.o_run_mode(run_mode), .bus(u_req.ctrl)
	);

	ads_sequencer #(.P_READ_HOLD(P_READ_HOLD)) u_seq (
		.i_CLK(i_CLK), .i_RST(i_RST), .o_ads_control(o_ads_control),
		.o_ads_reg_addr(o_ads_reg_addr), .o_ads_data_in(o_ads_data_in),
		.i_ads_reg_data(i_ads_reg_data), .i_ads_busy(i_ads_busy),
		.i_ads_sample(i_ads_sample), .i_ads_sample_valid(i_ads_sample_valid),
		.o_ads_sample_ack(o_ads_sample_ack), .bus(u_req.seq)
	);

endmodule

`default_nettype wire

//--- test/tb_ads_model.sv
/*
 * behavioral ADS link for the testbench, no reset of its own
 * busy lasts 2..5 random cycles after each WREG or RREG
 * read data is address XOR P_READ_XOR, writes logged in issue order
 * a pushed sample stays valid until an ack is seen
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ads_model import sensor_pkg::*; #(
	parameter logic [7:0] P_READ_XOR = 8'h5A
) (
	input  wire logic      i_CLK,
	input  wire ads_ctrl_e i_ads_control,
	input  wire reg_addr_t i_ads_reg_addr,
	input  wire reg_data_t i_ads_data_in,
	input  wire logic      i_ads_sample_ack,
	input  wire logic      i_push,        // one-cycle offer from the testbench
	input  wire sample_t   i_push_sample,
	output reg_data_t      o_ads_reg_data,
	output logic           o_ads_busy,
	output sample_t        o_ads_sample,
	output logic           o_ads_sample_valid
);

	reg_addr_t wr_addr [0:31];      // write log
	reg_data_t wr_data [0:31];
	int        wr_count = 0;
	int        op_count [8];        // every opcode seen, per cycle
	int        ack_count = 0;
	reg_addr_t last_rd_addr = '0;
	int        busy_cnt = 0;
	logic      busy = 1'b0;
	reg_data_t rd_data = '0;
	sample_t   smp = '0;
	logic      smp_valid = 1'b0;

	assign o_ads_busy         = busy;
	assign o_ads_reg_data     = rd_data;
	assign o_ads_sample       = smp;
	assign o_ads_sample_valid = smp_valid;

	always @(posedge i_CLK) begin : link
		ads_ctrl_e cmd;
		reg_addr_t addr;
		reg_data_t data;
		logic      ack;
		logic      push;
		sample_t   push_val;
		// values as they stood before this edge
		cmd = i_ads_control;
		addr = i_ads_reg_addr;
		data = i_ads_data_in;
		ack = i_ads_sample_ack;
		push = i_push;
		push_val = i_push_sample;
		#1; // outputs move just after the edge
		op_count[cmd]++;
		if (cmd == ADS_WREG || cmd == ADS_RREG)
			busy_cnt = 2 + int'($urandom % 4); // 2..5 cycles
		else if (busy_cnt > 0)
			busy_cnt--;
		busy = (busy_cnt > 0);
		if (cmd == ADS_WREG && wr_count < 32) begin
			wr_addr[wr_count] = addr;
			wr_data[wr_count] = data;
			wr_count++;
		end
		if (cmd == ADS_RREG) begin
			last_rd_addr = addr;
			rd_data = addr ^ P_READ_XOR;
		end
		if (ack) begin
			smp_valid = 1'b0; // sample handed over
			ack_count++;
		end
		if (push) begin
			smp = push_val;
			smp_valid = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- test/tb_sensor_core.sv
/*
 * directed testbench for sensor_core with a behavioral ADS link
 * inputs move 1 ns after the rising edge, outputs read at the falling edge
 * frames are collected wherever valid meets ready
 * a cycle watchdog bounds the whole run
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_core import sensor_pkg::*; ();

	localparam int         CLK_PERIOD  = 4;
	localparam int         DRIVE_DELAY = 1;
	localparam int         SEED        = 24754;
	localparam int         NUM_TESTS   = 5;
	localparam int         WAIT_LIMIT  = 300;    // cycles for any single wait
	localparam logic [7:0] READ_XOR    = 8'h5A;  // model read-data rule

	logic        i_CLK = 1'b0;
	logic        i_RST;
	host_frame_t o_uart_tx;
	logic        o_uart_tx_valid;
	logic        i_uart_tx_ready;
	logic [15:0] i_uart_rx;
	logic        i_uart_rx_valid;
	ads_ctrl_e   o_ads_control;
	reg_addr_t   o_ads_reg_addr;
	reg_data_t   o_ads_data_in;
	reg_data_t   i_ads_reg_data;
	logic        i_ads_init_set;
	logic        i_ads_busy;
	sample_t     i_ads_sample;
	logic        i_ads_sample_valid;
	logic        o_ads_sample_ack;
	logic        sample_push;          // offer strobe to the model
	sample_t     new_sample;
	host_frame_t frames [$];           // frames taken by the host
	int          valid_cycles = 0;
	int          checks = 0;
	int          errors = 0;

	always #(CLK_PERIOD / 2) i_CLK = ~i_CLK;

	sensor_core UUT (.*);

	tb_ads_model #(.P_READ_XOR(READ_XOR)) model (
		.i_CLK(i_CLK), .i_ads_control(o_ads_control), .i_ads_reg_addr(o_ads_reg_addr),
		.i_ads_data_in(o_ads_data_in), .i_ads_sample_ack(o_ads_sample_ack),
		.i_push(sample_push), .i_push_sample(new_sample), .o_ads_reg_data(i_ads_reg_data),
		.o_ads_busy(i_ads_busy), .o_ads_sample(i_ads_sample),
		.o_ads_sample_valid(i_ads_sample_valid)
	);

	always @(posedge i_CLK) begin
		if (o_uart_tx_valid) valid_cycles++;
		if (o_uart_tx_valid && i_uart_tx_ready) frames.push_back(o_uart_tx); // taken here
	end

	// ============================================================
	// checks and drivers
	// ============================================================
	task automatic check_frame(input string name, input host_frame_t got, input host_frame_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got_a, input reg_data_t got_d,
		input reg_addr_t exp_a, input reg_data_t exp_d);
		checks++;
		if (got_a !== exp_a || got_d !== exp_d) begin
			errors++;
			$display("CHECK FAILED %s got 0x%02h/0x%02h expected 0x%02h/0x%02h",
				name, got_a, got_d, exp_a, exp_d);
		end
	endtask

	task automatic check_ctrl(input string name, input ads_ctrl_e got, input ads_ctrl_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic expect_cond(input bit ok, input string msg);
		checks++;
		if (!ok) begin
			errors++;
			$display("ERROR: %s", msg);
		end
	endtask

	task automatic send_cmd(input host_cmd_e cmd, input logic [7:0] arg);
		@(posedge i_CLK);
		#DRIVE_DELAY;
		i_uart_rx = {cmd, arg};
		i_uart_rx_valid = 1'b1;
		@(posedge i_CLK);
		#DRIVE_DELAY;
		i_uart_rx_valid = 1'b0; // single-cycle strobe
	endtask

	task automatic present_sample(input sample_t s);
		@(posedge i_CLK);
		#DRIVE_DELAY;
		sample_push = 1'b1;
		new_sample = s;
		@(posedge i_CLK);
		#DRIVE_DELAY;
		sample_push = 1'b0;
	endtask

	task automatic offer_sample(input sample_t s);
		int acks;
		int n;
		acks = model.ack_count;
		present_sample(s);
		n = 0;
		while (model.ack_count == acks && n < WAIT_LIMIT) begin
			@(negedge i_CLK);
			n++;
		end
		expect_cond(model.ack_count != acks, $sformatf("sample 0x%06h never acked", s));
	endtask

	task automatic wait_opcode(input ads_ctrl_e op, input int target);
		int n;
		n = 0;
		while (model.op_count[op] < target && n < WAIT_LIMIT) begin
			@(negedge i_CLK);
			n++;
		end
		expect_cond(model.op_count[op] >= target, $sformatf("opcode 0x%h never issued", op));
	endtask

	task automatic wait_frame(output host_frame_t f);
		int n;
		n = 0;
		while (frames.size() == 0 && n < WAIT_LIMIT) begin
			@(negedge i_CLK);
			n++;
		end
		expect_cond(frames.size() != 0, "timed out waiting for a host frame");
		f = (frames.size() != 0) ? frames.pop_front() : '0;
	endtask

	// ============================================================
	// directed tests
	// ============================================================
	task automatic test_config();
		int n;
		repeat (20) @(negedge i_CLK); // link init still low
		expect_cond(model.wr_count == 0, "register write issued before link init");
		check_ctrl("o_ads_control", o_ads_control, ADS_DUMMY);
		@(posedge i_CLK);
		#DRIVE_DELAY;
		i_ads_init_set = 1'b1;
		n = 0;
		while (!(model.wr_count >= ADS_CFG_LEN && !i_ads_busy) && n < WAIT_LIMIT) begin
			@(negedge i_CLK);
			n++;
		end
		repeat (20) @(negedge i_CLK); // any stray write would show here
		expect_cond(model.wr_count == ADS_CFG_LEN,
			$sformatf("%0d register writes seen, expected %0d", model.wr_count, ADS_CFG_LEN));
		for (int i = 0; i < ADS_CFG_LEN && i < model.wr_count; i++)
			check_reg($sformatf("o_ads_reg_addr/o_ads_data_in write %0d", i), model.wr_addr[i],
				model.wr_data[i], ADS_CFG_TABLE[i].addr, ADS_CFG_TABLE[i].data);
	endtask

	task automatic test_stream();
		sample_t     s;
		host_frame_t f;
		send_cmd(CMD_RUN, 8'h00);
		wait_opcode(ADS_RDATAC, 1);
		for (int k = 0; k < 4; k++) begin
			s = sample_t'($urandom);
			offer_sample(s);
			wait_frame(f);
			check_frame("o_uart_tx", f, {8'hAA, s});
		end
		expect_cond(model.op_count[ADS_RDATAC] == 1, "RDATAC issued more than once");
	endtask

	task automatic test_backpressure();
		sample_t     s;
		host_frame_t f;
		int          seen;
		@(posedge i_CLK);
		#DRIVE_DELAY;
		i_uart_tx_ready = 1'b0;
		seen = valid_cycles;
		for (int k = 0; k < 3; k++) begin
			s = sample_t'($urandom);
			offer_sample(s); // older ones get overwritten
		end
		repeat (5) @(negedge i_CLK);
		expect_cond(valid_cycles == seen, "frame valid while ready was low");
		@(posedge i_CLK);
		#DRIVE_DELAY;
		i_uart_tx_ready = 1'b1;
		wait_frame(f);
		check_frame("o_uart_tx", f, {8'hAA, s}); // newest sample only
		repeat (20) @(negedge i_CLK);
		expect_cond(frames.size() == 0, "extra stream frame after back-pressure");
	endtask

	task automatic test_stop();
		int acks;
		int seen;
		send_cmd(CMD_STOP, 8'h00);
		wait_opcode(ADS_SDATAC, 1);
		acks = model.ack_count;
		seen = valid_cycles;
		present_sample(sample_t'($urandom)); // link keeps offering with nobody to take it
		repeat (40) @(negedge i_CLK);
		expect_cond(model.ack_count == acks, "sample acked after SDATAC");
		expect_cond(valid_cycles == seen, "stream frame after SDATAC");
		expect_cond(model.op_count[ADS_SDATAC] == 1, "SDATAC issued more than once");
		check_ctrl("o_ads_control", o_ads_control, ADS_DUMMY);
	endtask

	task automatic test_reg_read();
		reg_addr_t   addr;
		host_frame_t f;
		int          reads;
		for (int k = 0; k < 2; k++) begin
			addr = reg_addr_t'($urandom);
			reads = model.op_count[ADS_RREG];
			send_cmd(CMD_ADS_READ, addr);
			wait_opcode(ADS_RREG, reads + 1);
			wait_frame(f);
			check_reg("o_ads_reg_addr/o_uart_tx[15:8]", model.last_rd_addr, f[15:8],
				addr, addr ^ READ_XOR);
			check_frame("o_uart_tx", f, {8'h61, addr, addr ^ READ_XOR, 8'h00});
		end
	endtask

	// ============================================================
	// sequence and watchdog
	// ============================================================
	initial begin
		void'($urandom(SEED));
		i_RST = 1'b1;
		i_uart_rx = '0;
		i_uart_rx_valid = 1'b0;
		i_uart_tx_ready = 1'b1;
		i_ads_init_set = 1'b0;
		sample_push = 1'b0;
		new_sample = '0;
		repeat (3) @(posedge i_CLK);
		@(negedge i_CLK);
		check_ctrl("o_ads_control", o_ads_control, ADS_IDLE); // still in reset
		expect_cond(!o_uart_tx_valid && !o_ads_sample_ack, "outputs active during reset");
		repeat (2) @(posedge i_CLK);
		#DRIVE_DELAY;
		i_RST = 1'b0;
		test_config();
		test_stream();
		test_backpressure();
		test_stop();
		test_reg_read();
		repeat (5) @(posedge i_CLK);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin : watchdog
		repeat (NUM_TESTS * 2000) @(posedge i_CLK);
		$display("watchdog expired after %0d cycles, checks: %0d  errors: %0d",
			NUM_TESTS * 2000, checks, errors);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/sensor_pkg.sv
src/ads_req_if.sv
src/core_control.sv
src/host_link.sv
src/ads_sequencer.sv
src/sensor_core.sv
test/tb_ads_model.sv
test/tb_sensor_core.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_sensor_core
RTL_TOP  := sensor_core
FILELIST := verilog.f
OBJDIR   := obj_dir
PASS_MSG := TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
